/* rtl/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data SRAM window, word aligned base
`define LSU_SRAM_BASE   32'h8000_0000
`define LSU_SRAM_WORDS  1024

// CLINT window, inclusive bounds
`define LSU_CLINT_BASE  32'h0200_0000
`define LSU_CLINT_END   32'h0200_ffff

`endif

/* rtl/lsu_pkg.sv */
package lsu_pkg;

    // core mask code
    typedef enum logic [1:0] {
        MEM_NONE = 2'b00,
        MEM_BYTE = 2'b01,
        MEM_HALF = 2'b10,
        MEM_WORD = 2'b11
    } mem_size_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } bus_resp_e;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_ADDR,
        WRITE_DATA,
        WRITE_RESP,
        DONE
    } bus_state_e;

    typedef struct packed {
        logic        wen;
        logic        ren;
        logic        sign;
        mem_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] data;    // already shifted to byte lane
        logic [3:0]  strb;
        logic [2:0]  size;    // log2 of byte count
    } wr_beat_t;

    typedef struct packed {
        logic [31:0] data;
        bus_resp_e   resp;
    } rd_resp_t;

endpackage

/* rtl/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
    input  lsu_req_t req,
    output wr_beat_t beat
);

    logic [4:0] shamt;

    assign shamt = {req.addr[1:0], 3'b000};    // 8 * byte offset

    always_comb begin
        beat.data = req.wdata << shamt;
        case (req.size)
            MEM_BYTE: begin
                beat.strb = 4'b0001 << req.addr[1:0];
                beat.size = 3'd0;
            end
            MEM_HALF: begin
                beat.strb = req.addr[1] ? 4'b1100 : 4'b0011;
                beat.size = 3'd1;
            end
            MEM_WORD: begin
                beat.strb = 4'b1111;
                beat.size = 3'd2;
            end
            default: begin
                beat.strb = 4'b0000;    // nothing to store
                beat.size = 3'd0;
            end
        endcase
    end

endmodule

/* rtl/lsu_bus_ctrl.sv */
`timescale 1ns/1ps

module lsu_bus_ctrl import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  lsu_req_t  req,
    input  wr_beat_t  beat,
    output logic      arvalid,
    input  logic      arready,
    input  logic      rvalid,
    input  rd_resp_t  rresp,
    output logic      awvalid,
    input  logic      awready,
    output logic      wvalid,
    input  logic      wready,
    output wr_beat_t  wbeat,
    input  logic      bvalid,
    input  bus_resp_e bresp,
    output logic      busy,
    output logic      done,
    output logic      err
);

    bus_state_e state;
    bus_state_e state_nx;
    bus_resp_e  resp_q;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (start) begin
                    if (req.wen) begin
                        state_nx = WRITE_ADDR;
                    end else if (req.ren) begin
                        state_nx = READ_ADDR;
                    end else begin
                        state_nx = DONE;    // no bus access
                    end
                end
            end
            READ_ADDR:  if (arready) state_nx = READ_DATA;
            READ_DATA:  if (rvalid) state_nx = DONE;    // rready tied high
            WRITE_ADDR: if (awready) state_nx = WRITE_DATA;
            WRITE_DATA: if (wready) state_nx = WRITE_RESP;
            WRITE_RESP: if (bvalid) state_nx = DONE;    // bready tied high
            default:    state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            resp_q <= RESP_OKAY;
        end else begin
            state <= state_nx;
            if (state == IDLE && start) begin
                resp_q <= RESP_OKAY;
            end else if (state == READ_DATA && rvalid) begin
                resp_q <= rresp.resp;
            end else if (state == WRITE_RESP && bvalid) begin
                resp_q <= bresp;
            end
        end
    end

    // write beat held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            wbeat <= beat;
        end
    end

    assign arvalid = (state == READ_ADDR);
    assign awvalid = (state == WRITE_ADDR);
    assign wvalid  = (state == WRITE_DATA);

    assign busy = (state != IDLE);
    assign done = (state == DONE);
    assign err  = done && (resp_q != RESP_OKAY);

endmodule

/* rtl/lsu_addr_router.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_addr_router import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic [31:0] addr,
    input  logic      arvalid,
    output logic      arready,
    output logic      rvalid,
    output rd_resp_t  rresp,
    input  logic      awvalid,
    output logic      awready,
    input  logic      wvalid,
    output logic      wready,
    output logic      bvalid,
    output bus_resp_e bresp,
    output logic      sram_arvalid,
    input  logic      sram_arready,
    input  logic      sram_rvalid,
    input  rd_resp_t  sram_rresp,
    output logic      sram_awvalid,
    input  logic      sram_awready,
    output logic      sram_wvalid,
    input  logic      sram_wready,
    input  logic      sram_bvalid,
    input  bus_resp_e sram_bresp,
    output logic      clint_arvalid,
    input  logic      clint_arready,
    input  logic      clint_rvalid,
    input  rd_resp_t  clint_rresp
);

    localparam logic [31:0] SRAM_END = `LSU_SRAM_BASE + `LSU_SRAM_WORDS * 4 - 1;

    logic      is_sram;
    logic      is_clint;
    logic      loc_rvalid;
    logic      loc_bvalid;
    bus_resp_e loc_resp;

    assign is_sram  = (addr >= `LSU_SRAM_BASE) && (addr <= SRAM_END);
    assign is_clint = (addr >= `LSU_CLINT_BASE) && (addr <= `LSU_CLINT_END);

    assign sram_arvalid  = arvalid && is_sram;
    assign sram_awvalid  = awvalid && is_sram;
    assign sram_wvalid   = wvalid && is_sram;
    assign clint_arvalid = arvalid && is_clint;

    // unmapped reads and all non-SRAM writes are taken here
    assign arready = is_sram ? sram_arready : (is_clint ? clint_arready : 1'b1);
    assign awready = is_sram ? sram_awready : 1'b1;
    assign wready  = is_sram ? sram_wready : 1'b1;

    assign rvalid = is_sram ? sram_rvalid : (is_clint ? clint_rvalid : loc_rvalid);
    assign rresp  = is_sram  ? sram_rresp :
                    is_clint ? clint_rresp :
                    rd_resp_t'{data: 32'h0, resp: loc_resp};
    assign bvalid = is_sram ? sram_bvalid : loc_bvalid;
    assign bresp  = is_sram ? sram_bresp : loc_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            loc_rvalid <= 1'b0;
            loc_bvalid <= 1'b0;
        end else begin
            loc_rvalid <= arvalid && !is_sram && !is_clint;
            loc_bvalid <= wvalid && !is_sram;    // one cycle after W
        end
    end

    always_ff @(posedge clk) begin
        if ((arvalid || wvalid) && !is_sram) begin
            loc_resp <= is_clint ? RESP_SLVERR : RESP_DECERR;    // CLINT is read-only
        end
    end

endmodule

/* rtl/lsu_load_extract.sv */
`timescale 1ns/1ps

module lsu_load_extract import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rvalid,
    input  rd_resp_t    rresp,
    input  lsu_req_t    req,
    output logic [31:0] rdata
);

    logic [31:0] data_q;
    logic [31:0] shifted;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= 32'h0;
        end else if (rvalid) begin    // rready always high
            data_q <= rresp.data;
        end
    end

    assign shifted = data_q >> {req.addr[1:0], 3'b000};

    always_comb begin
        case (req.size)
            MEM_BYTE: rdata = {{24{shifted[7] & req.sign}}, shifted[7:0]};
            MEM_HALF: rdata = {{16{shifted[15] & req.sign}}, shifted[15:0]};
            MEM_WORD: rdata = shifted;
            default:  rdata = 32'h0;
        endcase
    end

endmodule

/* rtl/data_sram.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_sram import lsu_pkg::*; (
    input  logic        clk,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    output rd_resp_t    rresp,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  wr_beat_t    wbeat,
    output logic        bvalid,
    output bus_resp_e   bresp
);

    localparam int IDX_W = $clog2(`LSU_SRAM_WORDS);

    logic [31:0]      mem [`LSU_SRAM_WORDS];
    logic [31:0]      rdata_q;
    logic [IDX_W-1:0] widx_q;
    logic [IDX_W-1:0] ridx;

    assign arready = 1'b1;
    assign awready = 1'b1;
    assign wready  = 1'b1;

    assign ridx = araddr[IDX_W+1:2];

    // valids follow the transfers by one cycle
    always_ff @(posedge clk) begin
        rvalid <= arvalid;
        bvalid <= wvalid;
    end

    always_ff @(posedge clk) begin
        if (arvalid) begin
            rdata_q <= mem[ridx];
        end
        if (awvalid) begin
            widx_q <= awaddr[IDX_W+1:2];    // address phase
        end
    end

    always_ff @(posedge clk) begin
        if (wvalid) begin
            for (int i = 0; i < 4; i++) begin
                if (wbeat.strb[i]) begin
                    mem[widx_q][8*i +: 8] <= wbeat.data[8*i +: 8];
                end
            end
        end
    end

    assign rresp = '{data: rdata_q, resp: RESP_OKAY};
    assign bresp = RESP_OKAY;

endmodule

/* rtl/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    output rd_resp_t    rresp
);

    logic [63:0] mtime;
    logic [31:0] rdata_q;

    assign arready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime  <= 64'h0;
            rvalid <= 1'b0;
        end else begin
            mtime  <= mtime + 64'd1;    // cycles since reset
            rvalid <= arvalid;
        end
    end

    // half picked at the AR transfer
    always_ff @(posedge clk) begin
        if (arvalid) begin
            rdata_q <= araddr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

    assign rresp = '{data: rdata_q, resp: RESP_OKAY};

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  lsu_req_t    req,
    output logic [31:0] rdata,
    output logic        busy,
    output logic        done,
    output logic        err
);

    wr_beat_t  beat;
    wr_beat_t  wbeat;
    logic      arvalid, arready, rvalid;
    logic      awvalid, awready, wvalid, wready, bvalid;
    rd_resp_t  rresp;
    bus_resp_e bresp;

    logic      sram_arvalid, sram_arready, sram_rvalid;
    logic      sram_awvalid, sram_awready, sram_wvalid, sram_wready, sram_bvalid;
    rd_resp_t  sram_rresp;
    bus_resp_e sram_bresp;

    logic      clint_arvalid, clint_arready, clint_rvalid;
    rd_resp_t  clint_rresp;

    lsu_store_align u_align (
        .req  (req),
        .beat (beat)
    );

    lsu_bus_ctrl u_ctrl (
        .clk     (clk),     .rst     (rst),     .start   (start),
        .req     (req),     .beat    (beat),
        .arvalid (arvalid), .arready (arready),
        .rvalid  (rvalid),  .rresp   (rresp),
        .awvalid (awvalid), .awready (awready),
        .wvalid  (wvalid),  .wready  (wready),  .wbeat   (wbeat),
        .bvalid  (bvalid),  .bresp   (bresp),
        .busy    (busy),    .done    (done),    .err     (err)
    );

    lsu_addr_router u_router (
        .clk           (clk),           .rst           (rst),
        .addr          (req.addr),
        .arvalid       (arvalid),       .arready       (arready),
        .rvalid        (rvalid),        .rresp         (rresp),
        .awvalid       (awvalid),       .awready       (awready),
        .wvalid        (wvalid),        .wready        (wready),
        .bvalid        (bvalid),        .bresp         (bresp),
        .sram_arvalid  (sram_arvalid),  .sram_arready  (sram_arready),
        .sram_rvalid   (sram_rvalid),   .sram_rresp    (sram_rresp),
        .sram_awvalid  (sram_awvalid),  .sram_awready  (sram_awready),
        .sram_wvalid   (sram_wvalid),   .sram_wready   (sram_wready),
        .sram_bvalid   (sram_bvalid),   .sram_bresp    (sram_bresp),
        .clint_arvalid (clint_arvalid), .clint_arready (clint_arready),
        .clint_rvalid  (clint_rvalid),  .clint_rresp   (clint_rresp)
    );

    lsu_load_extract u_extract (
        .clk    (clk),
        .rst    (rst),
        .rvalid (rvalid),
        .rresp  (rresp),
        .req    (req),
        .rdata  (rdata)
    );

    data_sram u_sram (
        .clk     (clk),
        .arvalid (sram_arvalid), .arready (sram_arready), .araddr (req.addr),
        .rvalid  (sram_rvalid),  .rresp   (sram_rresp),
        .awvalid (sram_awvalid), .awready (sram_awready), .awaddr (req.addr),
        .wvalid  (sram_wvalid),  .wready  (sram_wready),  .wbeat  (wbeat),
        .bvalid  (sram_bvalid),  .bresp   (sram_bresp)
    );

    clint_timer u_clint (
        .clk     (clk),
        .rst     (rst),
        .arvalid (clint_arvalid),
        .arready (clint_arready),
        .araddr  (req.addr),
        .rvalid  (clint_rvalid),
        .rresp   (clint_rresp)
    );

endmodule

/* tb/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int N_RT = 12;
    // round trip, narrow stores, extension, clint, errors, idle
    localparam int N_XFERS = 2 * N_RT + 18 + 15 + 3 + 6 + 5;
    localparam int MAX_CYCLES = 8 * N_XFERS + 40;
    localparam logic [31:0] KNOWN_ADDR = `LSU_SRAM_BASE + 32'h100;
    localparam logic [31:0] CLINT_LO = `LSU_CLINT_BASE + 32'hbff8;
    localparam logic [31:0] UNMAPPED = 32'h1000_0040;

    logic        clk, rst, start, busy, done, err;
    logic [31:0] rdata;
    lsu_req_t    req;
    logic [7:0]  ref_mem [4 * `LSU_SRAM_WORDS];
    logic [31:0] lcg_state;
    int          cycles;

    lsu_top u_dut (
        .clk (clk), .rst (rst), .start (start), .req (req),
        .rdata (rdata), .busy (busy), .done (done), .err (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
                report_failure();
            end
        end
    end

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_word_addr();
        return `LSU_SRAM_BASE + (next_rand() & 32'h0000_0ffc);    // 1024 words
    endfunction

    function automatic lsu_req_t make_req(input logic wen, input logic ren, input logic sign,
                                          input mem_size_e size, input logic [31:0] addr,
                                          input logic [31:0] wdata);
        return '{wen: wen, ren: ren, sign: sign, size: size, addr: addr, wdata: wdata};
    endfunction

    function automatic void model_store(input logic [31:0] addr, input logic [31:0] data,
                                        input mem_size_e size);
        int off;
        off = int'(addr - `LSU_SRAM_BASE);
        if (size != MEM_NONE) ref_mem[off] = data[7:0];
        if (size == MEM_HALF || size == MEM_WORD) ref_mem[off + 1] = data[15:8];
        if (size == MEM_WORD) begin
            ref_mem[off + 2] = data[23:16];
            ref_mem[off + 3] = data[31:24];
        end
    endfunction

    function automatic logic [31:0] load_expect(input lsu_req_t r);
        int          off;
        logic [7:0]  b;
        logic [15:0] h;
        off = int'(r.addr - `LSU_SRAM_BASE);
        b = ref_mem[off];
        h = {ref_mem[off + 1], ref_mem[off]};    // halfwords stay 2-aligned
        case (r.size)
            MEM_BYTE: return r.sign ? {{24{b[7]}}, b} : {24'h0, b};
            MEM_HALF: return r.sign ? {{16{h[15]}}, h} : {16'h0, h};
            MEM_WORD: return {ref_mem[off + 3], ref_mem[off + 2], h};
            default:  return 32'h0;
        endcase
    endfunction

    // one transaction with busy watched until done
    task automatic run_xfer(input string name, input lsu_req_t r, output logic [31:0] rd,
                            output logic e);
        @(negedge clk);
        check_eq({name, " busy before start"}, 32'd0, busy);
        req = r;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1) begin
            check_eq({name, " busy"}, 32'd1, busy);
            @(negedge clk);
        end
        check_eq({name, " busy at done"}, 32'd1, busy);
        rd = rdata;
        e = err;
        @(negedge clk);
        check_eq({name, " busy after done"}, 32'd0, busy);
        check_eq({name, " done width"}, 32'd0, done);
    endtask

    task automatic store_ok(input string name, input logic [31:0] addr, input logic [31:0] data,
                            input mem_size_e size);
        logic [31:0] rd;
        logic        e;
        run_xfer(name, make_req(1'b1, 1'b0, 1'b0, size, addr, data), rd, e);
        check_eq({name, " err"}, 32'd0, e);
        model_store(addr, data, size);
    endtask

    task automatic load_check(input string name, input logic [31:0] addr, input mem_size_e size,
                              input logic sign);
        lsu_req_t    r;
        logic [31:0] rd;
        logic        e;
        r = make_req(1'b0, 1'b1, sign, size, addr, 32'h0);
        run_xfer(name, r, rd, e);
        check_eq({name, " err"}, 32'd0, e);
        check_eq(name, load_expect(r), rd);
    endtask

    task automatic word_round_trip();
        logic [31:0] addrs [N_RT];
        for (int i = 0; i < N_RT; i++) begin
            addrs[i] = rand_word_addr();
            store_ok("word store", addrs[i], next_rand(), MEM_WORD);
        end
        for (int i = 0; i < N_RT; i++) begin
            load_check("word read back", addrs[i], MEM_WORD, 1'b0);
        end
    endtask

    task automatic narrow_stores();
        logic [31:0] a;
        for (int off = 0; off < 4; off++) begin
            a = rand_word_addr();
            store_ok("fill word", a, next_rand(), MEM_WORD);
            store_ok("byte store", a + off, next_rand(), MEM_BYTE);
            load_check("word after byte store", a, MEM_WORD, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            a = rand_word_addr();
            store_ok("fill word", a, next_rand(), MEM_WORD);
            store_ok("half store", a + off, next_rand(), MEM_HALF);
            load_check("word after half store", a, MEM_WORD, 1'b0);
        end
    endtask

    task automatic load_extension();
        store_ok("known word", KNOWN_ADDR, 32'h5c9a_e713, MEM_WORD);    // mixed top bits
        for (int off = 0; off < 4; off++) begin
            load_check("byte load unsigned", KNOWN_ADDR + off, MEM_BYTE, 1'b0);
            load_check("byte load signed", KNOWN_ADDR + off, MEM_BYTE, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_check("half load unsigned", KNOWN_ADDR + off, MEM_HALF, 1'b0);
            load_check("half load signed", KNOWN_ADDR + off, MEM_HALF, 1'b1);
        end
        load_check("word load", KNOWN_ADDR, MEM_WORD, 1'b1);
        load_check("sizeless load", KNOWN_ADDR, MEM_NONE, 1'b1);
    endtask

    task automatic clint_reads();
        logic [31:0] lo1, lo2, hi;
        logic        e;
        int          seen;
        run_xfer("mtime low", make_req(1'b0, 1'b1, 1'b0, MEM_WORD, CLINT_LO, 32'h0), lo1, e);
        seen = cycles;
        check_eq("mtime low err", 32'd0, e);
        if (lo1 == 32'h0 || lo1 >= 32'(seen)) begin
            $display("mtime low word %0d is not between zero and %0d elapsed cycles", lo1, seen);
            report_failure();
        end
        run_xfer("mtime again", make_req(1'b0, 1'b1, 1'b0, MEM_WORD, CLINT_LO, 32'h0), lo2, e);
        check_eq("mtime again err", 32'd0, e);
        if (lo2 <= lo1) begin
            $display("second mtime read %0d did not advance past %0d", lo2, lo1);
            report_failure();
        end
        run_xfer("mtime high", make_req(1'b0, 1'b1, 1'b0, MEM_WORD, CLINT_LO + 4, 32'h0), hi, e);
        check_eq("mtime high err", 32'd0, e);
        check_eq("mtime high word", 32'd0, hi);
    endtask

    task automatic error_responses();
        logic [31:0] rd;
        logic        e;
        run_xfer("clint write", make_req(1'b1, 1'b0, 1'b0, MEM_WORD, CLINT_LO, next_rand()),
                 rd, e);
        check_eq("clint write err", 32'd1, e);
        load_check("read after clint write", KNOWN_ADDR, MEM_WORD, 1'b0);
        run_xfer("unmapped read", make_req(1'b0, 1'b1, 1'b0, MEM_WORD, UNMAPPED, 32'h0), rd, e);
        check_eq("unmapped read err", 32'd1, e);
        check_eq("unmapped read data", 32'd0, rd);
        load_check("read after unmapped read", KNOWN_ADDR, MEM_WORD, 1'b0);
        run_xfer("unmapped write", make_req(1'b1, 1'b0, 1'b0, MEM_WORD, UNMAPPED, next_rand()),
                 rd, e);
        check_eq("unmapped write err", 32'd1, e);
        load_check("read after unmapped write", KNOWN_ADDR, MEM_WORD, 1'b0);
    endtask

    task automatic idle_and_busy();
        logic [31:0] rd;
        logic        e;
        repeat (2) begin
            // an error response just before, so a stale err would show
            run_xfer("unmapped before idle",
                     make_req(1'b0, 1'b1, 1'b0, MEM_WORD, UNMAPPED, 32'h0), rd, e);
            check_eq("unmapped before idle err", 32'd1, e);
            run_xfer("idle request",
                     make_req(1'b0, 1'b0, 1'b0, MEM_WORD, KNOWN_ADDR, next_rand()), rd, e);
            check_eq("idle request err", 32'd0, e);
        end
        load_check("read after idle", KNOWN_ADDR, MEM_WORD, 1'b0);    // no stray store
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        req = '0;
        lcg_state = 32'd76038;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        word_round_trip();
        narrow_stores();
        load_extension();
        clint_reads();
        error_responses();
        idle_and_busy();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* lsu_top.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_bus_ctrl.sv
rtl/lsu_addr_router.sv
rtl/lsu_load_extract.sv
rtl/data_sram.sv
rtl/clint_timer.sv
rtl/lsu_top.sv
tb/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_store_align.sv
      - rtl/lsu_bus_ctrl.sv
      - rtl/lsu_addr_router.sv
      - rtl/lsu_load_extract.sv
      - rtl/data_sram.sv
      - rtl/clint_timer.sv
      - rtl/lsu_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/lsu_tb.sv
